// File: hw/dma_regs_pkg.sv
`default_nettype none

package dma_regs_pkg;

  // custom register word addresses (byte address / 2)
  localparam logic [7:0] dmacon_addr  = 8'h4b;  // 0x096 write
  localparam logic [7:0] dmaconr_addr = 8'h01;  // 0x002 read

  // dmacon write data
  localparam int dmacon_set_bit = 15;  // 1: set bits, 0: clear bits

  // dmacon bit positions
  localparam int dmaen_bit  = 9;   // master enable
  localparam int bltpri_bit = 10;  // blitter nasty
  localparam int bplen_bit  = 8;
  localparam int copen_bit  = 7;
  localparam int blten_bit  = 6;
  localparam int dsken_bit  = 4;

  localparam int dmacon_width = 13;  // stored bits 12..0

  // cpu access to the register bank
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [7:0]  addr;   // word address
    logic [15:0] wdata;
  } reg_bus_t;

endpackage

`default_nettype wire

// File: hw/chip_bus_pkg.sv
`default_nettype none

package chip_bus_pkg;

  // owner of a chip bus cycle
  typedef enum logic [2:0] {
    chan_cpu      = 3'd0,
    chan_disk     = 3'd1,
    chan_refresh  = 3'd2,
    chan_bitplane = 3'd3,
    chan_copper   = 3'd4,
    chan_blitter  = 3'd5
  } chan_t;

  localparam int slot_w      = 2;   // slot number is line position mod 4
  localparam int chip_addr_w = 20;  // word address into chip ram

  // one granted bus cycle
  typedef struct packed {
    chan_t                  chan;
    logic [chip_addr_w-1:0] addr;
    logic                   write;
  } grant_t;

  // channel enables, already qualified by dmaen
  typedef struct packed {
    logic dsk;
    logic bpl;
    logic cop;
    logic blt;
    logic bltpri;  // nasty mode, not gated by the master bit
  } dma_enables_t;

  // request half of a copper or blitter handshake
  typedef struct packed {
    logic                   req;
    logic [chip_addr_w-1:0] addr;   // held while req is high
    logic                   write;
  } dma_req_t;

endpackage

`default_nettype wire

// File: hw/dma_control.sv
`timescale 1ns/1ps
`default_nettype none

module dma_control (
  input  logic                       clk,
  input  logic                       reset,
  input  dma_regs_pkg::reg_bus_t     reg_bus,
  output logic [15:0]                reg_rdata,
  output chip_bus_pkg::dma_enables_t enables
);

  logic [dma_regs_pkg::dmacon_width-1:0] dmacon;  // stored control bits
  logic dmacon_wr;
  logic dmaconr_rd;
  logic master;

  assign dmacon_wr  = reg_bus.wr && (reg_bus.addr == dma_regs_pkg::dmacon_addr);
  assign dmaconr_rd = reg_bus.rd && (reg_bus.addr == dma_regs_pkg::dmaconr_addr);

  // ---------------------------------------------------------
  // set/clear write
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;
    end else if (dmacon_wr) begin
      if (reg_bus.wdata[dma_regs_pkg::dmacon_set_bit])
        dmacon <= dmacon | reg_bus.wdata[dma_regs_pkg::dmacon_width-1:0];  // set
      else
        dmacon <= dmacon & ~reg_bus.wdata[dma_regs_pkg::dmacon_width-1:0]; // clear
    end
  end

  // read bus is zero when not addressed so it can be or-ed with others
  // busy and zero bits are not implemented and read as 0
  assign reg_rdata = dmaconr_rd ? 16'(dmacon) : 16'h0000;

  // ---------------------------------------------------------
  // enables seen by the arbiter
  // ---------------------------------------------------------
  assign master = dmacon[dma_regs_pkg::dmaen_bit];

  always_comb begin
    enables.dsk    = dmacon[dma_regs_pkg::dsken_bit] & master;
    enables.bpl    = dmacon[dma_regs_pkg::bplen_bit] & master;
    enables.cop    = dmacon[dma_regs_pkg::copen_bit] & master;
    enables.blt    = dmacon[dma_regs_pkg::blten_bit] & master;
    enables.bltpri = dmacon[dma_regs_pkg::bltpri_bit];  // raw bit
  end

endmodule

`default_nettype wire

// File: hw/slot_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module slot_arbiter #(
  parameter int line_slots  = 228,  // slots per video line
  parameter int refresh_end = 16,   // refresh in slot 3 below this position
  parameter int bls_max     = 3     // blitter slowdown limit
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  chip_bus_pkg::dma_enables_t             enables,
  input  logic                                   disk_dmal,  // paula disk transfer request
  input  logic [chip_bus_pkg::chip_addr_w-1:0]   disk_addr,
  input  logic                                   disk_write,
  input  logic                                   bpl_fetch,  // bitplane fetch window
  input  logic [chip_bus_pkg::chip_addr_w-1:0]   bpl_addr,
  input  chip_bus_pkg::dma_req_t                 cop,
  input  chip_bus_pkg::dma_req_t                 blt,
  input  logic                                   bls,        // cpu is waiting for the bus
  input  logic                                   full,       // grant queue cannot take more
  output logic                                   cop_ack,
  output logic                                   blt_ack,
  output logic                                   dbr,        // chipset owns this slot
  output logic                                   cpu_custom,
  output logic                                   push,
  output chip_bus_pkg::grant_t                   grant
);

  localparam int pos_w = $clog2(line_slots);
  localparam int bls_w = $clog2(bls_max + 1);

  logic [pos_w-1:0]                pos;      // line position
  logic [chip_bus_pkg::slot_w-1:0] slot;
  logic [bls_w-1:0]                bls_cnt;  // missed cpu cycles
  logic                            odd_slot;
  logic                            dsk_win, ref_win, bpl_win, cop_win, blt_win;
  logic                            cop_sel, blt_sel;
  chip_bus_pkg::grant_t            grant_d;

  // ---------------------------------------------------------
  // slot counter
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      pos <= '0;
    else if (pos == pos_w'(line_slots - 1))
      pos <= '0;  // end of line
    else
      pos <= pos + 1'b1;
  end

  assign slot     = pos[chip_bus_pkg::slot_w-1:0];
  assign odd_slot = slot[0];  // slots 1 and 3

  // candidate requests, each already limited to its slots
  assign dsk_win = disk_dmal & enables.dsk & odd_slot;
  assign ref_win = (slot == 2'd3) && (pos < pos_w'(refresh_end));  // needs no enable
  assign bpl_win = bpl_fetch & enables.bpl & odd_slot;
  assign cop_win = cop.req & ~cop_ack & enables.cop & (slot == 2'd1);
  assign blt_win = blt.req & ~blt_ack & enables.blt & (slot != 2'd0)
                   & (bls_cnt != bls_w'(bls_max));  // blocked at the slowdown limit

  // ---------------------------------------------------------
  // fixed priority choice
  // ---------------------------------------------------------
  always_comb begin
    dbr           = 1'b1;
    cop_sel       = 1'b0;
    blt_sel       = 1'b0;
    grant_d.chan  = chip_bus_pkg::chan_cpu;
    grant_d.addr  = '0;
    grant_d.write = 1'b0;
    if (full) begin
      dbr = 1'b0;  // queue backed up, cpu keeps the slot
    end else if (dsk_win) begin
      grant_d.chan  = chip_bus_pkg::chan_disk;
      grant_d.addr  = disk_addr;
      grant_d.write = disk_write;
    end else if (ref_win) begin
      grant_d.chan = chip_bus_pkg::chan_refresh;  // no address, read only
    end else if (bpl_win) begin
      grant_d.chan = chip_bus_pkg::chan_bitplane;
      grant_d.addr = bpl_addr;
    end else if (cop_win) begin
      cop_sel       = 1'b1;
      grant_d.chan  = chip_bus_pkg::chan_copper;
      grant_d.addr  = cop.addr;
      grant_d.write = cop.write;
    end else if (blt_win) begin
      blt_sel       = 1'b1;
      grant_d.chan  = chip_bus_pkg::chan_blitter;
      grant_d.addr  = blt.addr;
      grant_d.write = blt.write;
    end else begin
      dbr = 1'b0;  // nothing wanted the slot
    end
  end

  assign cpu_custom = ~dbr;

  // winning grant goes to the queue at the end of the slot
  always_ff @(posedge clk) begin
    if (reset)
      push <= 1'b0;
    else
      push <= dbr;
  end

  always_ff @(posedge clk) begin
    grant <= grant_d;  // payload only
  end

  // ---------------------------------------------------------
  // four-phase acks to copper and blitter
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cop_ack <= 1'b0;
      blt_ack <= 1'b0;
    end else begin
      if (cop_sel)
        cop_ack <= 1'b1;
      else if (!cop.req)
        cop_ack <= 1'b0;  // requester has let go
      if (blt_sel)
        blt_ack <= 1'b1;
      else if (!blt.req)
        blt_ack <= 1'b0;
    end
  end

  // blitter slowdown, counted in the even (cpu) slots
  always_ff @(posedge clk) begin
    if (reset) begin
      bls_cnt <= '0;
    end else if (!odd_slot) begin
      if (!bls || enables.bltpri)
        bls_cnt <= '0;  // cpu got through or nasty mode
      else if (bls_cnt != bls_w'(bls_max))
        bls_cnt <= bls_cnt + 1'b1;
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (reset)
    !($rose(cop_ack) && $rose(blt_ack)));

endmodule

`default_nettype wire

// File: hw/grant_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module grant_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  chip_bus_pkg::grant_t din,
  output logic                 full,
  input  logic                 pop,
  output chip_bus_pkg::grant_t head,
  output logic                 empty
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  chip_bus_pkg::grant_t mem [fifo_depth];
  logic [ptr_w-1:0]     wr_ptr, rd_ptr;
  logic [cnt_w-1:0]     count;

  // ---------------------------------------------------------
  // storage and pointers
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  // the arbiter pushes one cycle after it decides, so a push in flight
  // takes the last free entry
  assign full  = (count == cnt_w'(fifo_depth))
              || (push && (count == cnt_w'(fifo_depth - 1)));

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> (count != cnt_w'(fifo_depth)));

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule

`default_nettype wire

// File: hw/chip_mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module chip_mem_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  chip_bus_pkg::grant_t head,
  input  logic                 empty,
  output logic                 pop,
  output logic                 mem_req,
  output chip_bus_pkg::grant_t mem_cmd,
  input  logic                 mem_ack
);

  typedef enum logic [1:0] {
    st_idle,     // waiting for a grant
    st_ack_hi,   // req up, waiting for ack
    st_ack_lo    // req down, waiting for ack to drop
  } state_t;

  state_t state;

  // ---------------------------------------------------------
  // four-phase cycle control
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      mem_req <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!empty) begin
            mem_req <= 1'b1;  // cmd latched on the same edge
            state   <= st_ack_hi;
          end
        end
        st_ack_hi: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= st_ack_lo;
          end
        end
        st_ack_lo: begin
          if (!mem_ack)
            state <= st_idle;  // cycle done, entry retired
        end
        default: begin
          state   <= st_idle;
          mem_req <= 1'b0;
        end
      endcase
    end
  end

  // command register, loaded only when a cycle starts
  always_ff @(posedge clk) begin
    if (state == st_idle && !empty)
      mem_cmd <= head;
  end

  // head stays in the queue until memory has finished with it
  assign pop = (state == st_ack_lo) && !mem_ack;

  a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_req && $past(mem_req)) |-> $stable(mem_cmd));

endmodule

`default_nettype wire

// File: hw/agnus_dma.sv
`timescale 1ns/1ps
`default_nettype none

module agnus_dma #(
  parameter int line_slots  = 228,
  parameter int refresh_end = 16,
  parameter int bls_max     = 3,
  parameter int fifo_depth  = 4
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  dma_regs_pkg::reg_bus_t               reg_bus,     // cpu register access
  output logic [15:0]                          reg_rdata,
  input  logic                                 disk_dmal,
  input  logic [chip_bus_pkg::chip_addr_w-1:0] disk_addr,
  input  logic                                 disk_write,
  input  logic                                 bpl_fetch,
  input  logic [chip_bus_pkg::chip_addr_w-1:0] bpl_addr,
  input  chip_bus_pkg::dma_req_t               cop,
  output logic                                 cop_ack,
  input  chip_bus_pkg::dma_req_t               blt,
  output logic                                 blt_ack,
  input  logic                                 bls,
  output logic                                 dbr,
  output logic                                 cpu_custom,
  output logic                                 mem_req,     // chip memory handshake
  output chip_bus_pkg::grant_t                 mem_cmd,
  input  logic                                 mem_ack
);

  chip_bus_pkg::dma_enables_t enables;
  chip_bus_pkg::grant_t       grant, head;
  logic                       push, full, pop, empty;

  // ---------------------------------------------------------
  // register block and arbiter
  // ---------------------------------------------------------
  dma_control i_dma_control (
    .clk       (clk),
    .reset     (reset),
    .reg_bus   (reg_bus),
    .reg_rdata (reg_rdata),
    .enables   (enables)
  );

  slot_arbiter #(
    .line_slots  (line_slots),
    .refresh_end (refresh_end),
    .bls_max     (bls_max)
  ) i_slot_arbiter (
    .clk        (clk),
    .reset      (reset),
    .enables    (enables),
    .disk_dmal  (disk_dmal),
    .disk_addr  (disk_addr),
    .disk_write (disk_write),
    .bpl_fetch  (bpl_fetch),
    .bpl_addr   (bpl_addr),
    .cop        (cop),
    .blt        (blt),
    .bls        (bls),
    .full       (full),
    .cop_ack    (cop_ack),
    .blt_ack    (blt_ack),
    .dbr        (dbr),
    .cpu_custom (cpu_custom),
    .push       (push),
    .grant      (grant)
  );

  // ---------------------------------------------------------
  // grant queue and memory side
  // ---------------------------------------------------------
  grant_fifo #(
    .fifo_depth (fifo_depth)
  ) i_grant_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .din   (grant),
    .full  (full),
    .pop   (pop),
    .head  (head),
    .empty (empty)
  );

  chip_mem_sequencer i_chip_mem_sequencer (
    .clk     (clk),
    .reset   (reset),
    .head    (head),
    .empty   (empty),
    .pop     (pop),
    .mem_req (mem_req),
    .mem_cmd (mem_cmd),
    .mem_ack (mem_ack)
  );

endmodule

`default_nettype wire

// File: bench/tb_agnus_dma_props.svh
`ifndef tb_agnus_dma_props_svh
`define tb_agnus_dma_props_svh

  int n_pass = 0;
  int n_fail = 0;

  function automatic void record_failure(input string msg);
    n_fail++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endfunction

  // ------------------------------------------------------------
  // reset state and register read-back
  // ------------------------------------------------------------
  p_reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> (!dbr && !cop_ack && !blt_ack && !mem_req))
    n_pass++; else record_failure("outputs not low after reset");

  // unaddressed reads must give zero too
  p_read_back: assert property (@(posedge clk) disable iff (reset)
    reg_rdata == exp_rdata)
    n_pass++; else record_failure("register read data differs from DMACON image");

  // ------------------------------------------------------------
  // slot ownership
  // ------------------------------------------------------------
  p_dbr_model: assert property (@(posedge clk) disable iff (reset)
    dbr == m_dbr)
    n_pass++; else record_failure("dbr differs from model slot owner");

  p_cpu_slot0: assert property (@(posedge clk) disable iff (reset)
    (m_slot == 2'd0) |-> !dbr)
    n_pass++; else record_failure("dbr high in slot 0");

  p_custom: assert property (@(posedge clk) disable iff (reset)
    cpu_custom == !dbr)
    n_pass++; else record_failure("cpu_custom not the inverse of dbr");

  p_refresh: assert property (@(posedge clk) disable iff (reset)
    (m_slot == 2'd3 && m_pos < refresh_end && !m_full) |-> dbr)
    n_pass++; else record_failure("refresh slot not taken");

  p_backpressure: assert property (@(posedge clk) disable iff (reset)
    m_full |-> !dbr)   // cpu owns every slot while the queue is full
    n_pass++; else record_failure("DMA slot granted with queue full");

  // ------------------------------------------------------------
  // copper and blitter handshakes
  // ------------------------------------------------------------
  p_cop_ack: assert property (@(posedge clk) disable iff (reset)
    $rose(cop_ack) |-> ($past(cop.req) && $past(m_slot) == 2'd1 && $past(m_cop_sel)))
    n_pass++; else record_failure("copper ack without a slot 1 win");

  p_blt_ack: assert property (@(posedge clk) disable iff (reset)
    $rose(blt_ack) |-> ($past(blt.req) && $past(m_blt_sel) && $past(m_bls) != bls_max))
    n_pass++; else record_failure("blitter ack at slowdown limit or without request");

  p_cop_hold: assert property (@(posedge clk) disable iff (reset)
    $fell(cop.req) |-> cop_ack)
    n_pass++; else record_failure("copper req dropped before ack");

  p_blt_hold: assert property (@(posedge clk) disable iff (reset)
    $fell(blt.req) |-> blt_ack)
    n_pass++; else record_failure("blitter req dropped before ack");

  p_ack_release: assert property (@(posedge clk) disable iff (reset)
    (cop_ack && !cop.req) |=> !cop_ack)
    n_pass++; else record_failure("copper ack held after req fell");

  p_blt_release: assert property (@(posedge clk) disable iff (reset)
    (blt_ack && !blt.req) |=> !blt_ack)
    n_pass++; else record_failure("blitter ack held after req fell");

  // each memory command must be the oldest expected grant
  p_cmd_order: assert property (@(posedge clk) disable iff (reset)
    $rose(mem_req) |-> (mem_cmd == exp_head))
    n_pass++; else record_failure("memory command out of order or wrong payload");

`endif

// File: bench/tb_agnus_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_agnus_dma;

  localparam int line_slots  = 48;  // short lines so refresh comes round often
  localparam int refresh_end = 16;
  localparam int bls_max     = 3;
  localparam int fifo_depth  = 4;
  localparam int period      = 20;  // ns
  localparam int n_reg_ops   = 12;
  localparam int len_slots   = 3 * line_slots;
  localparam int len_slow    = 160;
  localparam int len_bls     = 60;
  // summed test lengths, drains and margin, in cycles
  localparam int len_total   = 5 + 3 * n_reg_ops + len_slots + len_slow + 2 * len_bls
                               + 4 * fifo_depth * 40 + 500;
  localparam logic [15:0] set_all = 16'h8000;
  localparam logic [15:0] dmaen   = 16'(1 << dma_regs_pkg::dmaen_bit);
  localparam logic [15:0] bltpri  = 16'(1 << dma_regs_pkg::bltpri_bit);
  localparam logic [15:0] blten   = 16'(1 << dma_regs_pkg::blten_bit);
  localparam logic [15:0] all_dma = dmaen | blten | 16'(1 << dma_regs_pkg::dsken_bit)
                                    | 16'(1 << dma_regs_pkg::bplen_bit)
                                    | 16'(1 << dma_regs_pkg::copen_bit);

  logic                                 clk, reset;
  dma_regs_pkg::reg_bus_t               reg_bus;
  logic [15:0]                          reg_rdata;
  logic                                 disk_dmal, disk_write, bpl_fetch, bls;
  logic [chip_bus_pkg::chip_addr_w-1:0] disk_addr, bpl_addr;
  chip_bus_pkg::dma_req_t               cop, blt;
  logic                                 cop_ack, blt_ack, dbr, cpu_custom;
  logic                                 mem_req, mem_ack;
  chip_bus_pkg::grant_t                 mem_cmd;
  integer                               seed = 32'hbf0f_7b34;
  logic                                 cop_run, blt_run, mem_slow;
  logic                                 retire;  // memory cycle ends at the next edge

  // reference model state
  int                                    m_pos, m_bls, m_cnt;
  logic [dma_regs_pkg::dmacon_width-1:0] m_dmacon;  // DMACON image
  logic [1:0]                            m_slot;
  logic                                  m_full, m_dbr, m_push, req_prev;
  logic                                  m_cop_ack, m_blt_ack, m_cop_sel, m_blt_sel;
  logic                                  en_dsk, en_bpl, en_cop, en_blt, nasty;
  logic [15:0]                           exp_rdata;
  chip_bus_pkg::grant_t                  m_grant, exp_head;
  chip_bus_pkg::grant_t                  exp_q[$];  // expected grant queue

  agnus_dma #(
    .line_slots  (line_slots),
    .refresh_end (refresh_end),
    .bls_max     (bls_max),
    .fifo_depth  (fifo_depth)
  ) i_agnus_dma (
    .clk        (clk),
    .reset      (reset),
    .reg_bus    (reg_bus),
    .reg_rdata  (reg_rdata),
    .disk_dmal  (disk_dmal),
    .disk_addr  (disk_addr),
    .disk_write (disk_write),
    .bpl_fetch  (bpl_fetch),
    .bpl_addr   (bpl_addr),
    .cop        (cop),
    .cop_ack    (cop_ack),
    .blt        (blt),
    .blt_ack    (blt_ack),
    .bls        (bls),
    .dbr        (dbr),
    .cpu_custom (cpu_custom),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_ack    (mem_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(len_total * period);
    $display("watchdog: run did not finish within %0d cycles", len_total);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  assign m_slot    = 2'(m_pos % 4);
  assign en_dsk    = m_dmacon[dma_regs_pkg::dsken_bit] && m_dmacon[dma_regs_pkg::dmaen_bit];
  assign en_bpl    = m_dmacon[dma_regs_pkg::bplen_bit] && m_dmacon[dma_regs_pkg::dmaen_bit];
  assign en_cop    = m_dmacon[dma_regs_pkg::copen_bit] && m_dmacon[dma_regs_pkg::dmaen_bit];
  assign en_blt    = m_dmacon[dma_regs_pkg::blten_bit] && m_dmacon[dma_regs_pkg::dmaen_bit];
  assign nasty     = m_dmacon[dma_regs_pkg::bltpri_bit];
  assign m_full    = (m_cnt == fifo_depth) || (m_push && m_cnt == fifo_depth - 1);
  assign exp_rdata = (reg_bus.rd && reg_bus.addr == dma_regs_pkg::dmaconr_addr)
                     ? 16'(m_dmacon) : 16'h0000;

  // slot owner by priority: disk, refresh, bitplane, copper, blitter, else cpu
  always_comb begin
    m_dbr     = 1'b1;
    m_cop_sel = 1'b0;
    m_blt_sel = 1'b0;
    m_grant   = '0;
    if (m_full)
      m_dbr = 1'b0;
    else if (disk_dmal && en_dsk && m_slot[0])
      m_grant = {chip_bus_pkg::chan_disk, disk_addr, disk_write};
    else if (m_slot == 2'd3 && m_pos < refresh_end)
      m_grant.chan = chip_bus_pkg::chan_refresh;
    else if (bpl_fetch && en_bpl && m_slot[0])
      m_grant = {chip_bus_pkg::chan_bitplane, bpl_addr, 1'b0};
    else if (cop.req && !m_cop_ack && en_cop && m_slot == 2'd1) begin
      m_cop_sel = 1'b1;
      m_grant   = {chip_bus_pkg::chan_copper, cop.addr, cop.write};
    end else if (blt.req && !m_blt_ack && en_blt && m_slot != 2'd0 && m_bls != bls_max) begin
      m_blt_sel = 1'b1;
      m_grant   = {chip_bus_pkg::chan_blitter, blt.addr, blt.write};
    end else
      m_dbr = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      m_pos     <= 0;
      m_dmacon  <= '0;
      m_bls     <= 0;
      m_cop_ack <= 1'b0;
      m_blt_ack <= 1'b0;
      m_push    <= 1'b0;
      m_cnt     <= 0;
      req_prev  <= 1'b0;
      exp_head  <= '0;
      exp_q.delete();
    end else begin
      m_pos <= (m_pos == line_slots - 1) ? 0 : m_pos + 1;
      if (reg_bus.wr && reg_bus.addr == dma_regs_pkg::dmacon_addr) begin
        if (reg_bus.wdata[dma_regs_pkg::dmacon_set_bit])
          m_dmacon <= m_dmacon | reg_bus.wdata[dma_regs_pkg::dmacon_width-1:0];
        else
          m_dmacon <= m_dmacon & ~reg_bus.wdata[dma_regs_pkg::dmacon_width-1:0];
      end
      if (!m_slot[0])  // slowdown counts in cpu slots only
        m_bls <= (!bls || nasty) ? 0 : ((m_bls < bls_max) ? m_bls + 1 : m_bls);
      m_cop_ack <= m_cop_sel || (m_cop_ack && cop.req);
      m_blt_ack <= m_blt_sel || (m_blt_ack && blt.req);
      m_push    <= m_dbr;
      m_cnt     <= m_cnt + int'(m_push) - int'(retire);
      if (mem_req && !req_prev)
        void'(exp_q.pop_front());  // oldest grant went out to memory
      if (m_dbr)
        exp_q.push_back(m_grant);
      exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
      req_prev <= mem_req;
    end
  end

  `include "tb_agnus_dma_props.svh"

  // ------------------------------------------------------------
  // copper, blitter and memory responders
  // ------------------------------------------------------------
  initial begin : requesters
    forever begin
      @(posedge clk);
      #2;
      if (cop.req && cop_ack)
        cop.req = 1'b0;  // ack seen, let go
      else if (cop_run && !cop.req && !cop_ack) begin
        cop.addr = 20'($random(seed));
        cop.req  = 1'b1;
      end
      if (blt.req && blt_ack)
        blt.req = 1'b0;
      else if (blt_run && !blt.req && !blt_ack) begin
        blt.addr  = 20'($random(seed));
        blt.write = 1'($random(seed));
        blt.req   = 1'b1;
      end
    end
  end

  // mem_req is looked at 2 ns after the edge, once it has settled
  initial begin : memory_responder
    int unsigned wait_n;
    forever begin
      @(posedge clk);
      #2;
      if (mem_req) begin
        wait_n = mem_slow ? 4 + $unsigned($random(seed)) % 12 : $unsigned($random(seed)) % 2;
        repeat (wait_n) begin
          @(posedge clk);
          #2;
        end
        mem_ack = 1'b1;
        do begin
          @(posedge clk);
          #2;
        end while (mem_req);
        wait_n = mem_slow ? $unsigned($random(seed)) % 8 : 0;
        repeat (wait_n) begin
          @(posedge clk);
          #2;
        end
        mem_ack = 1'b0;
        retire  = 1'b1;
        @(posedge clk);
        #2 retire = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic reg_access(input logic rd, input logic wr, input logic [7:0] addr,
                            input logic [15:0] data);
    reg_bus = {rd, wr, addr, data};
    next_cycle();
    reg_bus = '0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || mem_req || mem_ack || cop.req || blt.req)
      next_cycle();
  endtask

  task automatic end_test(input string name);
    $display("test %-12s done at %0t ns, failures so far %0d", name, $time, n_fail);
  endtask

  initial begin : stimulus
    reset      = 1'b1;
    reg_bus    = '0;
    disk_dmal  = 1'b0;
    disk_addr  = '0;
    disk_write = 1'b0;
    bpl_fetch  = 1'b0;
    bpl_addr   = '0;
    cop        = '0;
    blt        = '0;
    bls        = 1'b0;
    mem_ack    = 1'b0;
    cop_run    = 1'b0;
    blt_run    = 1'b0;
    mem_slow   = 1'b0;
    retire     = 1'b0;
    repeat (5) @(posedge clk);
    #2 reset = 1'b0;

    reg_access(1'b1, 1'b0, dma_regs_pkg::dmaconr_addr, 16'h0);
    end_test("reset");

    for (int i = 0; i < n_reg_ops; i++) begin
      reg_access(1'b0, 1'b1, dma_regs_pkg::dmacon_addr, 16'($random(seed)));
      reg_access(1'b1, 1'b0, dma_regs_pkg::dmaconr_addr, 16'h0);
      reg_access(1'b1, 1'b0, 8'($random(seed)), 16'h0);  // mostly unmapped
    end
    end_test("dmacon");

    reg_access(1'b0, 1'b1, dma_regs_pkg::dmacon_addr, 16'h7fff);  // clear everything
    reg_access(1'b0, 1'b1, dma_regs_pkg::dmacon_addr, set_all | all_dma);
    cop_run = 1'b1;
    blt_run = 1'b1;
    for (int i = 0; i < len_slots; i++) begin
      disk_dmal  = ($random(seed) & 3) == 0;
      disk_addr  = 20'($random(seed));
      disk_write = 1'($random(seed));
      bpl_fetch  = (i % line_slots) >= 20 && (i % line_slots) < 36;  // fetch window
      bpl_addr   = bpl_addr + 1'b1;
      next_cycle();
    end
    disk_dmal = 1'b0;
    bpl_fetch = 1'b0;
    cop_run   = 1'b0;
    blt_run   = 1'b0;
    drain();
    end_test("slots");

    // slow memory, queue fills and the cpu gets every slot
    mem_slow  = 1'b1;
    cop_run   = 1'b1;
    blt_run   = 1'b1;
    disk_dmal = 1'b1;
    repeat (len_slow) begin
      disk_addr = disk_addr + 1'b1;
      next_cycle();
    end
    disk_dmal = 1'b0;
    cop_run   = 1'b0;
    blt_run   = 1'b0;
    mem_slow  = 1'b0;
    drain();
    end_test("backpressure");

    reg_access(1'b0, 1'b1, dma_regs_pkg::dmacon_addr, 16'h7fff);
    reg_access(1'b0, 1'b1, dma_regs_pkg::dmacon_addr, set_all | dmaen | blten);
    bls     = 1'b1;  // cpu keeps asking
    blt_run = 1'b1;
    repeat (len_bls) next_cycle();
    reg_access(1'b0, 1'b1, dma_regs_pkg::dmacon_addr, set_all | bltpri);
    repeat (len_bls) next_cycle();
    bls     = 1'b0;
    blt_run = 1'b0;
    drain();
    end_test("slowdown");

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
hw/dma_regs_pkg.sv
hw/chip_bus_pkg.sv
hw/dma_control.sv
hw/slot_arbiter.sv
hw/grant_fifo.sv
hw/chip_mem_sequencer.sv
hw/agnus_dma.sv
bench/tb_agnus_dma.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_agnus_dma
FLAGS     ?= -Wno-fatal
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f project.f $(FLAGS) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
